//--- sim.f
src/cw_io_pkg.sv
src/cw_reg_bank.sv
src/trig_combiner.sv
src/targetio_router.sv
src/userio_dir.sv
src/cw_io_top.sv
testbench/cw_io_checker.sv
testbench/tb_cw_io.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_cw_io
FILELIST = sim.f
PASS_MSG = Verification passed
EXE      = obj_dir/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, fail unless it passes"
	@echo "  clean  remove the build directory"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(EXE))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

//--- testbench/tb_cw_io.sv
module tb_cw_io import cw_io_pkg::*; ();

   localparam int CLK_PERIOD    = 20;
   localparam int RESET_CYCLES  = 8;
   localparam int N_STEPS       = 4000;
   localparam int WATCHDOG_TIME = (N_STEPS + RESET_CYCLES + 300) * CLK_PERIOD; // plus slack

   logic                    clk_usb;
   logic                    reset;
   logic [7:0]              reg_address_i, reg_datai_i, reg_datao_o;
   logic [BYTECNT_W-1:0]    reg_bytecnt_i;
   logic                    reg_read_i, reg_write_i;
   logic                    trigger_nrst_i, trigger_io1_i, trigger_io2_i, trigger_io3_i;
   logic                    trigger_io4_i, trigger_advio_i, trigger_sad_i;
   logic                    trigger_decodedio_i, trigger_trace_i, trigger_adc_i;
   logic                    trigger_o, trigger_ext_o, decodeio_active_o, sad_active_o;
   logic [NUM_TARGETIO-1:0] targetio_in_i, targetio_out_o, targetio_oe_o;
   logic                    uart_tx_i, uart_rx_o, targetpower_off_o, enable_avrprog_o;
   logic                    enable_output_nrst_o, output_nrst_o;
   logic                    enable_output_pdid_o, output_pdid_o;
   logic                    enable_output_pdic_o, output_pdic_o;
   logic                    trace_en_i, userio_clk_i, trace_exists_i, la_exists_i;
   logic [USERIO_W-1:0]     trace_userio_dir_i, userio_d_i, userio_cwdriven_o;
   logic [USERIO_W-1:0]     userio_drive_data_o;
   logic                    userio_fpga_debug_o, userio_target_debug_o, userio_target_debug_swd_o;
   int                      err_count, chk_count;
   integer                  seed;
   logic [7:0]              addr_list [13];   // every mapped address plus one hole

   cw_io_top i_cw_io_top (.*);

   cw_io_checker i_checker (.*, .error_count_o(err_count), .check_count_o(chk_count));

   initial begin
      clk_usb = 1'b0;
      forever #(CLK_PERIOD / 2) clk_usb = ~clk_usb;
   end

   initial begin
      #(WATCHDOG_TIME);
      $display("Timeout: the run did not finish within %0d time units", WATCHDOG_TIME);
      $display("Verification failed");
      $finish;
   end

   function automatic logic [31:0] next_rand();
      next_rand = $random(seed);
   endfunction

   // one bus cycle driven shortly after the rising edge
   task automatic bus_cycle(input logic wr, input logic rd, input logic [7:0] addr,
                            input logic [BYTECNT_W-1:0] bc, input logic [7:0] data);
      @(posedge clk_usb);
      #2;
      reg_write_i   = wr;
      reg_read_i    = rd;
      reg_address_i = addr;
      reg_bytecnt_i = bc;
      reg_datai_i   = data;
   endtask

   // fresh levels on all non-bus inputs
   task automatic shuffle_inputs();
      logic [31:0] a;
      logic [31:0] b;
      a = next_rand();
      b = next_rand();
      {trigger_nrst_i, trigger_io1_i, trigger_io2_i, trigger_io3_i, trigger_io4_i} = a[4:0];
      {trigger_advio_i, trigger_sad_i, trigger_decodedio_i} = a[7:5];
      {trigger_trace_i, trigger_adc_i} = a[9:8];
      targetio_in_i      = a[13:10];
      uart_tx_i          = a[14];
      trace_en_i         = (a[17:15] == 3'd0);  // rare so lower priorities show
      userio_clk_i       = a[18];
      trace_exists_i     = a[19];
      la_exists_i        = a[20];
      trace_userio_dir_i = b[7:0];
      userio_d_i         = b[15:8];
   endtask

   initial begin
      logic [31:0]          r;
      logic [31:0]          d;
      logic [7:0]           a;
      logic [BYTECNT_W-1:0] bc;
      seed          = 71;
      reset         = 1'b1;
      reg_write_i   = 1'b0;
      reg_read_i    = 1'b0;
      reg_address_i = 8'h00;
      reg_bytecnt_i = '0;
      reg_datai_i   = 8'h00;
      shuffle_inputs();
      addr_list = '{AUX_IO, EXTCLK, TRIGSRC, TRIGMOD, IOROUTE, IOREAD, USERIO_CW_DRIVEN,
                    USERIO_DEBUG_DRIVEN, USERIO_READ, USERIO_DRIVE_DATA, EXTERNAL_CLOCK,
                    COMPONENTS_EXIST, 8'd100};
      repeat (RESET_CYCLES) @(posedge clk_usb);
      #2;
      reset = 1'b0;
      // reset values of bytes 0 and 1 everywhere
      foreach (addr_list[k]) begin
         bus_cycle(1'b0, 1'b1, addr_list[k], '0, 8'h00);
         bus_cycle(1'b0, 1'b1, addr_list[k], BYTECNT_W'(1), 8'h00);
      end
      for (int b = 0; b <= IOROUTE_BYTES; b++) begin
         bus_cycle(1'b0, 1'b1, IOROUTE, BYTECNT_W'(b), 8'h00);
      end
      // write then read back
      foreach (addr_list[k]) begin
         r = next_rand();
         bus_cycle(1'b1, 1'b0, addr_list[k], '0, r[7:0]);
         bus_cycle(1'b0, 1'b1, addr_list[k], '0, 8'h00);
      end
      for (int b = 0; b <= IOROUTE_BYTES; b++) begin  // byte 8 is out of range
         r = next_rand();
         bus_cycle(1'b1, 1'b0, IOROUTE, BYTECNT_W'(b), r[7:0]);
         bus_cycle(1'b0, 1'b1, IOROUTE, BYTECNT_W'(b), 8'h00);
      end
      repeat (N_STEPS) begin
         r  = next_rand();
         d  = next_rand();
         a  = addr_list[int'(r[31:8] % 24'd13)];
         bc = (a == IOROUTE) ? BYTECNT_W'(r[7:4] % 4'd10) : BYTECNT_W'(r[5:4]);
         case (r[3:0] % 4'd10)
            4'd0, 4'd1, 4'd2, 4'd3: bus_cycle(1'b1, 1'b0, a, bc, d[7:0]);
            4'd4, 4'd5, 4'd6: begin
               bus_cycle(1'b0, 1'b1, a, bc, 8'h00);
               if (d[0]) shuffle_inputs();  // pins move under the read so ioread must lag
            end
            default: begin
               bus_cycle(1'b0, 1'b0, a, bc, 8'h00);
               shuffle_inputs();
            end
         endcase
      end
      repeat (3) bus_cycle(1'b0, 1'b0, 8'h00, '0, 8'h00);
      @(negedge clk_usb);
      #1;                                 // after the last compare
      $display("Checks run: %0d, errors: %0d", chk_count, err_count);
      if (err_count == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

//--- testbench/cw_io_checker.sv
module cw_io_checker import cw_io_pkg::*; (
   input  logic                    clk_usb,
   input  logic                    reset,
   input  logic [7:0]              reg_address_i,
   input  logic [BYTECNT_W-1:0]    reg_bytecnt_i,
   input  logic [7:0]              reg_datai_i,
   input  logic                    reg_read_i,
   input  logic                    reg_write_i,
   input  logic [7:0]              reg_datao_o,
   input  logic                    trigger_nrst_i, trigger_io1_i, trigger_io2_i, trigger_io3_i,
   input  logic                    trigger_io4_i, trigger_advio_i, trigger_sad_i,
   input  logic                    trigger_decodedio_i, trigger_trace_i, trigger_adc_i,
   input  logic                    trigger_o, trigger_ext_o, decodeio_active_o, sad_active_o,
   input  logic [NUM_TARGETIO-1:0] targetio_in_i, targetio_out_o, targetio_oe_o,
   input  logic                    uart_tx_i, uart_rx_o, targetpower_off_o, enable_avrprog_o,
   input  logic                    enable_output_nrst_o, output_nrst_o,
   input  logic                    enable_output_pdid_o, output_pdid_o,
   input  logic                    enable_output_pdic_o, output_pdic_o,
   input  logic                    trace_en_i,
   input  logic [USERIO_W-1:0]     trace_userio_dir_i, userio_d_i,
   input  logic                    userio_clk_i,
   input  logic [USERIO_W-1:0]     userio_cwdriven_o, userio_drive_data_o,
   input  logic                    userio_fpga_debug_o, userio_target_debug_o,
   input  logic                    userio_target_debug_swd_o, trace_exists_i, la_exists_i,
   output int                      error_count_o,
   output int                      check_count_o
);

   logic [7:0]  trigsrc_m;
   logic [7:0]  trigmod_m;   // full byte, low 3 bits pick the module
   logic [63:0] route_m;
   logic [7:0]  cwdrv_m;
   logic [2:0]  dbg_m;       // swd, target, fpga
   logic [7:0]  drive_m;
   logic        aux_m;
   logic [7:0]  extclk_m;
   logic        extclock_m;
   logic        pwr_m;       // power off as seen on the pin
   logic [3:0]  ioread_m;
   int          bc;
   int          errors = 0;
   int          checks = 0;

   assign bc            = int'(reg_bytecnt_i);
   assign error_count_o = errors;
   assign check_count_o = checks;

   // shadow registers, same edges as the bank
   always @(posedge clk_usb) begin
      if (reset) begin
         trigsrc_m  <= TRIGSRC_RST;
         trigmod_m  <= 8'h00;
         route_m    <= IOROUTE_RST;
         cwdrv_m    <= 8'h00;
         dbg_m      <= 3'b000;
         drive_m    <= 8'h00;
         aux_m      <= 1'b0;
         extclk_m   <= EXTCLK_RST;
         extclock_m <= 1'b0;
         pwr_m      <= 1'b0;
         ioread_m   <= 4'h0;
      end else begin
         pwr_m    <= route_m[EXTRA_BYTE*8 + EXTRA_PWR_OFF]; // one more stage after the reg
         ioread_m <= targetio_in_i;
         if (reg_write_i) begin
            case (reg_address_i)
               AUX_IO:              aux_m      <= reg_datai_i[0];
               EXTCLK:              extclk_m   <= reg_datai_i;
               TRIGSRC:             trigsrc_m  <= reg_datai_i;
               TRIGMOD:             trigmod_m  <= reg_datai_i;
               IOROUTE:             if (bc < IOROUTE_BYTES) route_m[bc*8 +: 8] <= reg_datai_i;
               USERIO_CW_DRIVEN:    if (bc == 0) cwdrv_m <= reg_datai_i;
               USERIO_DEBUG_DRIVEN: dbg_m      <= reg_datai_i[2:0];
               USERIO_DRIVE_DATA:   if (bc == 0) drive_m <= reg_datai_i;
               EXTERNAL_CLOCK:      extclock_m <= reg_datai_i[0];
               default: ;           // read-only and unmapped
            endcase
         end
      end
   end

   function automatic logic exp_trig_ext();
      logic [4:0] lines;
      logic       any_hi;
      logic       all_hi;
      lines  = {trigger_io4_i, trigger_io3_i, trigger_io2_i, trigger_io1_i, trigger_nrst_i};
      any_hi = 1'b0;
      all_hi = 1'b1;                  // nothing selected counts as all high
      for (int n = 0; n < 5; n++) begin
         if (trigsrc_m[n + 1]) begin
            any_hi = any_hi | lines[n];
            all_hi = all_hi & lines[n];
         end
      end
      case (trigsrc_m[7:6])
         2'd0:    return any_hi;
         2'd1:    return all_hi;
         2'd2:    return ~all_hi;
         default: return 1'b0;
      endcase
   endfunction

   function automatic logic exp_trigger();
      case (trigmod_m[2:0])
         3'd0:    return exp_trig_ext();
         3'd1:    return trigger_advio_i;
         3'd2:    return trigger_sad_i;
         3'd3:    return trigger_decodedio_i;
         3'd4:    return trigger_trace_i;
         3'd5:    return trigger_adc_i;
         default: return 1'b0;
      endcase
   endfunction

   // {enable before power blanking, level}
   function automatic logic [1:0] exp_pin(input int i);
      logic [7:0] rb;
      rb = route_m[i*8 +: 8];
      if (rb[IOR_TX]) return {1'b1, uart_tx_i};
      if (i == 2 && rb[IOR_USIO_OC]) return 2'b10;
      if (i == 2 && rb[IOR_USOC]) return {~uart_tx_i, 1'b0};  // pulls low only
      if (rb[IOR_GPIO_EN]) return {1'b1, rb[IOR_GPIO_LVL]};
      return 2'b00;
   endfunction

   function automatic logic exp_rx();
      for (int n = 0; n < NUM_TARGETIO; n++) begin
         if (route_m[n*8 + IOR_RX]) return targetio_in_i[n];
      end
      return 1'b1;
   endfunction

   function automatic logic [USERIO_W-1:0] exp_dir();
      if (trace_en_i) return trace_userio_dir_i;
      if (dbg_m[0]) return 8'hff;
      if (dbg_m[1] && dbg_m[2]) return userio_clk_i ? SWD_DIR_CLK_HIGH : SWD_DIR_CLK_LOW;
      if (dbg_m[1]) return JTAG_DIR;
      return cwdrv_m;
   endfunction

   function automatic logic [7:0] exp_read();
      case (reg_address_i)
         AUX_IO:              return {7'b0, aux_m};
         EXTCLK:              return extclk_m;
         TRIGSRC:             return trigsrc_m;
         TRIGMOD:             return trigmod_m;
         IOROUTE:             return (bc < IOROUTE_BYTES) ? route_m[bc*8 +: 8] : 8'h00;
         IOREAD:              return {4'b0, ioread_m};
         USERIO_CW_DRIVEN:    return (bc == 0) ? exp_dir() : 8'h00;
         USERIO_DEBUG_DRIVEN: return {5'b0, dbg_m};
         USERIO_READ:         return (bc == 0) ? userio_d_i : (bc == 1) ? {7'b0, userio_clk_i} : 8'h00;
         USERIO_DRIVE_DATA:   return (bc == 0) ? drive_m : 8'h00;
         EXTERNAL_CLOCK:      return {7'b0, extclock_m};
         COMPONENTS_EXIST:    return {6'b0, trace_exists_i, la_exists_i};
         default:             return 8'h00;
      endcase
   endfunction

   task automatic check_bit(input string what, input logic got, input logic exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Fail at %0t: %s is %b, expected %b", $time, what, got, exp);
      end
   endtask

   task automatic check_byte(input string what, input logic [7:0] got, input logic [7:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Fail at %0t: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   // mid-cycle compare, inputs and comb paths settled
   always @(negedge clk_usb) begin
      logic [1:0] pin;
      if (!reset) begin
         check_byte("read data", reg_datao_o, reg_read_i ? exp_read() : 8'h00);
         check_bit("trigger_ext", trigger_ext_o, exp_trig_ext());
         check_bit("trigger", trigger_o, exp_trigger());
         check_bit("decodeio_active", decodeio_active_o, trigmod_m[2:0] == DECODEDIO);
         check_bit("sad_active", sad_active_o, trigmod_m[2:0] == SAD);
         for (int i = 0; i < NUM_TARGETIO; i++) begin
            pin = exp_pin(i);
            check_bit($sformatf("pin %0d enable", i + 1), targetio_oe_o[i], pin[1] & ~pwr_m);
            if (pin[1]) check_bit($sformatf("pin %0d level", i + 1), targetio_out_o[i], pin[0]);
         end
         check_bit("uart_rx", uart_rx_o, exp_rx());
         check_bit("power off", targetpower_off_o, pwr_m);
         check_bit("avr enable", enable_avrprog_o, route_m[EXTRA_BYTE*8 + EXTRA_AVR]);
         check_bit("nrst enable", enable_output_nrst_o, route_m[EXGPIO_BYTE*8 + EXGPIO_NRST_EN]);
         check_bit("nrst level", output_nrst_o, route_m[EXGPIO_BYTE*8 + EXGPIO_NRST]);
         check_bit("pdid enable", enable_output_pdid_o, route_m[EXGPIO_BYTE*8 + EXGPIO_PDID_EN]);
         check_bit("pdid level", output_pdid_o, route_m[EXGPIO_BYTE*8 + EXGPIO_PDID]);
         check_bit("pdic enable", enable_output_pdic_o, route_m[EXGPIO_BYTE*8 + EXGPIO_PDIC_EN]);
         check_bit("pdic level", output_pdic_o, route_m[EXGPIO_BYTE*8 + EXGPIO_PDIC]);
         check_byte("userio direction", userio_cwdriven_o, exp_dir());
         check_byte("userio drive data", userio_drive_data_o, drive_m);
         check_bit("fpga debug", userio_fpga_debug_o, dbg_m[0]);
         check_bit("target debug", userio_target_debug_o, dbg_m[1]);
         check_bit("target debug swd", userio_target_debug_swd_o, dbg_m[2]);
      end
   end

endmodule

//--- src/cw_io_top.sv
module cw_io_top import cw_io_pkg::*; (
   input  logic                    clk_usb,
   input  logic                    reset,
   input  logic [7:0]              reg_address_i,
   input  logic [BYTECNT_W-1:0]    reg_bytecnt_i,
   input  logic [7:0]              reg_datai_i,
   input  logic                    reg_read_i,
   input  logic                    reg_write_i,
   output logic [7:0]              reg_datao_o,
   input  logic                    trigger_nrst_i,
   input  logic                    trigger_io1_i,
   input  logic                    trigger_io2_i,
   input  logic                    trigger_io3_i,
   input  logic                    trigger_io4_i,
   input  logic                    trigger_advio_i,
   input  logic                    trigger_sad_i,
   input  logic                    trigger_decodedio_i,
   input  logic                    trigger_trace_i,
   input  logic                    trigger_adc_i,
   output logic                    trigger_o,
   output logic                    trigger_ext_o,
   output logic                    decodeio_active_o,
   output logic                    sad_active_o,
   input  logic [NUM_TARGETIO-1:0] targetio_in_i,
   output logic [NUM_TARGETIO-1:0] targetio_out_o,
   output logic [NUM_TARGETIO-1:0] targetio_oe_o,
   input  logic                    uart_tx_i,
   output logic                    uart_rx_o,
   output logic                    targetpower_off_o,
   output logic                    enable_avrprog_o,
   output logic                    enable_output_nrst_o,
   output logic                    output_nrst_o,
   output logic                    enable_output_pdid_o,
   output logic                    output_pdid_o,
   output logic                    enable_output_pdic_o,
   output logic                    output_pdic_o,
   input  logic                    trace_en_i,
   input  logic [USERIO_W-1:0]     trace_userio_dir_i,
   input  logic [USERIO_W-1:0]     userio_d_i,
   input  logic                    userio_clk_i,
   output logic [USERIO_W-1:0]     userio_cwdriven_o,
   output logic [USERIO_W-1:0]     userio_drive_data_o,
   output logic                    userio_fpga_debug_o,
   output logic                    userio_target_debug_o,
   output logic                    userio_target_debug_swd_o,
   input  logic                    trace_exists_i,
   input  logic                    la_exists_i
);

   logic [7:0]              trigsrc;
   logic [2:0]              trigmod;
   logic [63:0]             iorouting;
   logic [USERIO_W-1:0]     cwdriven_reg;
   logic [NUM_TARGETIO-1:0] ioread;

   cw_reg_bank i_cw_reg_bank (
      .clk_usb, .reset, .reg_address_i, .reg_bytecnt_i, .reg_datai_i,
      .reg_read_i, .reg_write_i, .reg_datao_o,
      .ioread_i           (ioread),
      .userio_cwdriven_i  (userio_cwdriven_o),   // readback of resolved direction
      .userio_d_i, .userio_clk_i, .trace_exists_i, .la_exists_i,
      .trigsrc_o          (trigsrc),
      .trigmod_o          (trigmod),
      .iorouting_o        (iorouting),
      .cwdriven_reg_o     (cwdriven_reg),
      .fpga_debug_o       (userio_fpga_debug_o),
      .target_debug_o     (userio_target_debug_o),
      .target_debug_swd_o (userio_target_debug_swd_o),
      .userio_drive_data_o
   );

   trig_combiner i_trig_combiner (
      .trigsrc_i (trigsrc), .trigmod_i (trigmod),
      .trigger_nrst_i, .trigger_io1_i, .trigger_io2_i, .trigger_io3_i, .trigger_io4_i,
      .trigger_advio_i, .trigger_sad_i, .trigger_decodedio_i, .trigger_trace_i,
      .trigger_adc_i, .trigger_o, .trigger_ext_o, .decodeio_active_o, .sad_active_o
   );

   targetio_router i_targetio_router (
      .clk_usb, .reset,
      .iorouting_i (iorouting),
      .targetio_in_i, .uart_tx_i, .targetio_out_o, .targetio_oe_o, .uart_rx_o,
      .ioread_o    (ioread),
      .targetpower_off_o, .enable_avrprog_o,
      .enable_output_nrst_o, .output_nrst_o, .enable_output_pdid_o, .output_pdid_o,
      .enable_output_pdic_o, .output_pdic_o
   );

   userio_dir i_userio_dir (
      .trace_en_i, .trace_userio_dir_i,
      .fpga_debug_i       (userio_fpga_debug_o),
      .target_debug_i     (userio_target_debug_o),
      .target_debug_swd_i (userio_target_debug_swd_o),
      .userio_clk_i,
      .cwdriven_reg_i     (cwdriven_reg),
      .userio_cwdriven_o
   );

endmodule

//--- src/userio_dir.sv
module userio_dir import cw_io_pkg::*; (
   input  logic                trace_en_i,
   input  logic [USERIO_W-1:0] trace_userio_dir_i,
   input  logic                fpga_debug_i,
   input  logic                target_debug_i,
   input  logic                target_debug_swd_i,
   input  logic                userio_clk_i,
   input  logic [USERIO_W-1:0] cwdriven_reg_i,
   output logic [USERIO_W-1:0] userio_cwdriven_o   // 1 = driven by us
);

   // trace > fpga debug > swd > jtag > register
   always_comb begin
      if (trace_en_i)
         userio_cwdriven_o = trace_userio_dir_i;
      else if (fpga_debug_i)
         userio_cwdriven_o = '1;                      // everything out
      else if (target_debug_i && target_debug_swd_i)
         userio_cwdriven_o = userio_clk_i ? SWD_DIR_CLK_HIGH : SWD_DIR_CLK_LOW; // swdio turn
      else if (target_debug_i)
         userio_cwdriven_o = JTAG_DIR;
      else
         userio_cwdriven_o = cwdriven_reg_i;
   end

endmodule

//--- src/targetio_router.sv
module targetio_router import cw_io_pkg::*; (
   input  logic                    clk_usb,
   input  logic                    reset,
   input  logic [63:0]             iorouting_i,
   input  logic [NUM_TARGETIO-1:0] targetio_in_i,
   input  logic                    uart_tx_i,
   output logic [NUM_TARGETIO-1:0] targetio_out_o,
   output logic [NUM_TARGETIO-1:0] targetio_oe_o,
   output logic                    uart_rx_o,
   output logic [NUM_TARGETIO-1:0] ioread_o,
   output logic                    targetpower_off_o,
   output logic                    enable_avrprog_o,
   output logic                    enable_output_nrst_o,
   output logic                    output_nrst_o,
   output logic                    enable_output_pdid_o,
   output logic                    output_pdid_o,
   output logic                    enable_output_pdic_o,
   output logic                    output_pdic_o
);

   logic [7:0] extra;
   logic [7:0] extra_gpio;

   assign extra      = iorouting_i[EXTRA_BYTE*8 +: 8];
   assign extra_gpio = iorouting_i[EXGPIO_BYTE*8 +: 8];

   // power switch lags the register by one clock
   always_ff @(posedge clk_usb) begin
      if (reset) targetpower_off_o <= 1'b0;
      else       targetpower_off_o <= extra[EXTRA_PWR_OFF];
   end

   for (genvar i = 0; i < NUM_TARGETIO; i++) begin : g_pin
      localparam bit HAS_OC = (i == 2);  // only pin 3 has the open-collector modes
      logic [7:0] rb;
      logic       pin_out;
      logic       pin_oe;

      assign rb = iorouting_i[i*8 +: 8];

      always_comb begin
         pin_out = 1'b0;
         pin_oe  = 1'b0;
         if (rb[IOR_TX]) begin
            pin_out = uart_tx_i;
            pin_oe  = 1'b1;
         end else if (HAS_OC && rb[IOR_USIO_OC]) begin
            pin_oe  = 1'b1;                // hard low
         end else if (HAS_OC && rb[IOR_USOC]) begin
            pin_oe  = ~uart_tx_i;          // pull low only and release on 1
         end else if (rb[IOR_GPIO_EN]) begin
            pin_out = rb[IOR_GPIO_LVL];
            pin_oe  = 1'b1;
         end
      end

      assign targetio_out_o[i] = pin_out;
      assign targetio_oe_o[i]  = pin_oe & ~targetpower_off_o;  // all hi-z while unpowered
   end

   // lowest pin with rx set wins and rx idles high
   always_comb begin
      uart_rx_o = 1'b1;
      for (int k = NUM_TARGETIO - 1; k >= 0; k--) begin
         if (iorouting_i[k*8 + IOR_RX]) uart_rx_o = targetio_in_i[k];
      end
   end

   always_ff @(posedge clk_usb) begin
      if (reset) ioread_o <= '0;
      else       ioread_o <= targetio_in_i;   // pin snapshot
   end

   assign enable_avrprog_o     = extra[EXTRA_AVR];
   assign enable_output_nrst_o = extra_gpio[EXGPIO_NRST_EN];
   assign output_nrst_o        = extra_gpio[EXGPIO_NRST];
   assign enable_output_pdid_o = extra_gpio[EXGPIO_PDID_EN];
   assign output_pdid_o        = extra_gpio[EXGPIO_PDID];
   assign enable_output_pdic_o = extra_gpio[EXGPIO_PDIC_EN];
   assign output_pdic_o        = extra_gpio[EXGPIO_PDIC];

   // a pin drives only if the power-off bit was clear one clock earlier
   a_no_drive_unpowered: assert property (@(posedge clk_usb) disable iff (reset)
      (|targetio_oe_o) |-> !$past(extra[EXTRA_PWR_OFF]));

endmodule

//--- src/trig_combiner.sv
module trig_combiner import cw_io_pkg::*; (
   input  logic [7:0] trigsrc_i,   // [5:1] line enables, [7:6] combine mode
   input  logic [2:0] trigmod_i,
   input  logic       trigger_nrst_i,
   input  logic       trigger_io1_i,
   input  logic       trigger_io2_i,
   input  logic       trigger_io3_i,
   input  logic       trigger_io4_i,
   input  logic       trigger_advio_i,
   input  logic       trigger_sad_i,
   input  logic       trigger_decodedio_i,
   input  logic       trigger_trace_i,
   input  logic       trigger_adc_i,
   output logic       trigger_o,
   output logic       trigger_ext_o,
   output logic       decodeio_active_o,
   output logic       sad_active_o
);

   logic [4:0]    lines;
   logic [4:0]    sel;
   logic          trig_or;
   logic          trig_and;
   trig_combine_e comb;
   trig_mode_e    mode;

   assign lines = {trigger_io4_i, trigger_io3_i, trigger_io2_i, trigger_io1_i, trigger_nrst_i};
   assign sel   = trigsrc_i[5:1];
   assign comb  = trig_combine_e'(trigsrc_i[7:6]);
   assign mode  = trig_mode_e'(trigmod_i);

   assign trig_or  = |(lines & sel);
   assign trig_and = &(lines | ~sel);  // unselected lines count as true

   always_comb begin
      case (comb)
         OR:      trigger_ext_o = trig_or;
         AND:     trigger_ext_o = trig_and;
         NAND:    trigger_ext_o = ~trig_and;
         default: trigger_ext_o = 1'b0;  // reserved
      endcase
   end

   always_comb begin
      case (mode)
         EDGE:      trigger_o = trigger_ext_o;
         ADVIO:     trigger_o = trigger_advio_i;
         SAD:       trigger_o = trigger_sad_i;
         DECODEDIO: trigger_o = trigger_decodedio_i;
         TRACE:     trigger_o = trigger_trace_i;
         ADC:       trigger_o = trigger_adc_i;
         default:   trigger_o = 1'b0;
      endcase
   end

   assign decodeio_active_o = (mode == DECODEDIO);
   assign sad_active_o      = (mode == SAD);

endmodule

//--- src/cw_reg_bank.sv
module cw_reg_bank import cw_io_pkg::*; (
   input  logic                 clk_usb,
   input  logic                 reset,
   input  logic [7:0]           reg_address_i,
   input  logic [BYTECNT_W-1:0] reg_bytecnt_i,
   input  logic [7:0]           reg_datai_i,
   input  logic                 reg_read_i,
   input  logic                 reg_write_i,
   input  logic [3:0]           ioread_i,
   input  logic [USERIO_W-1:0]  userio_cwdriven_i,  // resolved direction for readback only
   input  logic [USERIO_W-1:0]  userio_d_i,
   input  logic                 userio_clk_i,
   input  logic                 trace_exists_i,
   input  logic                 la_exists_i,
   output logic [7:0]           reg_datao_o,
   output logic [7:0]           trigsrc_o,
   output logic [2:0]           trigmod_o,
   output logic [63:0]          iorouting_o,
   output logic [USERIO_W-1:0]  cwdriven_reg_o,
   output logic                 fpga_debug_o,
   output logic                 target_debug_o,
   output logic                 target_debug_swd_o,
   output logic [USERIO_W-1:0]  userio_drive_data_o
);

   reg_addr_e         addr;
   logic              aux_io_q;     // storage only as aux clock out is not built
   logic [7:0]        extclk_q;     // storage only
   logic [7:0]        trigmod_q;    // upper bits kept for readback
   logic              ext_clock_q;
   logic              ioroute_byte_ok;
   logic              byte0;
   logic              byte1;
   logic [USERIO_W:0] userio_read;  // clk on top of data

   assign addr            = reg_addr_e'(reg_address_i);
   assign ioroute_byte_ok = (reg_bytecnt_i < BYTECNT_W'(IOROUTE_BYTES));
   assign byte0           = (reg_bytecnt_i == '0);
   assign byte1           = (reg_bytecnt_i == BYTECNT_W'(1));
   assign userio_read     = {userio_clk_i, userio_d_i};
   assign trigmod_o       = trigmod_q[2:0];

   // write decode
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         aux_io_q            <= 1'b0;
         extclk_q            <= EXTCLK_RST;
         trigsrc_o           <= TRIGSRC_RST;
         trigmod_q           <= 8'h00;           // edge mode
         iorouting_o         <= IOROUTE_RST;
         cwdriven_reg_o      <= '0;
         fpga_debug_o        <= 1'b0;
         target_debug_o      <= 1'b0;
         target_debug_swd_o  <= 1'b0;
         userio_drive_data_o <= '0;
         ext_clock_q         <= 1'b0;
      end else if (reg_write_i) begin
         case (addr)
            AUX_IO:  aux_io_q  <= reg_datai_i[0];
            EXTCLK:  extclk_q  <= reg_datai_i;
            TRIGSRC: trigsrc_o <= reg_datai_i;
            TRIGMOD: trigmod_q <= reg_datai_i;
            IOROUTE: begin
               if (ioroute_byte_ok) // bytes 8+ dropped
                  iorouting_o[{reg_bytecnt_i[IOROUTE_IDX_W-1:0], 3'b000} +: 8] <= reg_datai_i;
            end
            USERIO_CW_DRIVEN: begin
               if (byte0) cwdriven_reg_o <= reg_datai_i;
            end
            USERIO_DEBUG_DRIVEN: begin
               fpga_debug_o       <= reg_datai_i[0];
               target_debug_o     <= reg_datai_i[1];
               target_debug_swd_o <= reg_datai_i[2];
            end
            USERIO_DRIVE_DATA: begin
               if (byte0) userio_drive_data_o <= reg_datai_i;
            end
            EXTERNAL_CLOCK: ext_clock_q <= reg_datai_i[0];
            default: ;                                 // read-only or unmapped
         endcase
      end
   end

   // readback mux in the same cycle as the read strobe
   always_comb begin
      reg_datao_o = 8'h00;
      if (reg_read_i) begin
         case (addr)
            AUX_IO:  reg_datao_o = {7'b0, aux_io_q};
            EXTCLK:  reg_datao_o = extclk_q;
            TRIGSRC: reg_datao_o = trigsrc_o;
            TRIGMOD: reg_datao_o = trigmod_q;
            IOROUTE: begin
               if (ioroute_byte_ok)
                  reg_datao_o = iorouting_o[{reg_bytecnt_i[IOROUTE_IDX_W-1:0], 3'b000} +: 8];
            end
            IOREAD: reg_datao_o = {4'b0, ioread_i};
            USERIO_CW_DRIVEN: begin
               if (byte0) reg_datao_o = userio_cwdriven_i; // after priority and not the raw reg
            end
            USERIO_DEBUG_DRIVEN:
               reg_datao_o = {5'b0, target_debug_swd_o, target_debug_o, fpga_debug_o};
            USERIO_READ: begin
               if (byte0)
                  reg_datao_o = userio_read[7:0];
               else if (byte1)
                  reg_datao_o = {7'b0, userio_read[USERIO_W]};
            end
            USERIO_DRIVE_DATA: begin
               if (byte0) reg_datao_o = userio_drive_data_o;
            end
            EXTERNAL_CLOCK:   reg_datao_o = {7'b0, ext_clock_q};
            COMPONENTS_EXIST: reg_datao_o = {6'b0, trace_exists_i, la_exists_i};
            default: ;
         endcase
      end
   end

   // routing word only moves on an in-range IOROUTE write
   a_ioroute_hold: assert property (@(posedge clk_usb) disable iff (reset)
      !(reg_write_i && addr == IOROUTE && ioroute_byte_ok) |=> $stable(iorouting_o));

endmodule

//--- src/cw_io_pkg.sv
package cw_io_pkg;

   localparam int BYTECNT_W     = 7;
   localparam int USERIO_W      = 8;
   localparam int NUM_TARGETIO  = 4;
   localparam int IOROUTE_BYTES = 8;
   localparam int IOROUTE_IDX_W = $clog2(IOROUTE_BYTES);

   // host register map, documented numbers kept where known
   typedef enum logic [7:0] {
      AUX_IO              = 8'd37,
      EXTCLK              = 8'd38,
      TRIGSRC             = 8'd39,
      TRIGMOD             = 8'd40,
      IOROUTE             = 8'd55,
      IOREAD              = 8'd59,
      USERIO_CW_DRIVEN    = 8'd60,
      USERIO_DEBUG_DRIVEN = 8'd61,
      USERIO_READ         = 8'd62,
      USERIO_DRIVE_DATA   = 8'd63,
      EXTERNAL_CLOCK      = 8'd64,
      COMPONENTS_EXIST    = 8'd65
   } reg_addr_e;

   // trigger module select, 6 and 7 reserved
   typedef enum logic [2:0] {
      EDGE      = 3'd0,
      ADVIO     = 3'd1,
      SAD       = 3'd2,
      DECODEDIO = 3'd3,
      TRACE     = 3'd4,
      ADC       = 3'd5
   } trig_mode_e;

   // combine mode in trigsrc[7:6], 3 reserved (trigger held low)
   typedef enum logic [1:0] {
      OR   = 2'd0,
      AND  = 2'd1,
      NAND = 2'd2
   } trig_combine_e;

   // gpio routing byte, one per target pin
   localparam int IOR_TX       = 0;
   localparam int IOR_RX       = 1;
   localparam int IOR_USIO_OC  = 4;  // pin 3 only, drive low
   localparam int IOR_USOC     = 5;  // pin 3 only, open drain tx
   localparam int IOR_GPIO_LVL = 6;
   localparam int IOR_GPIO_EN  = 7;

   localparam int EXTRA_BYTE    = 5;
   localparam int EXTRA_AVR     = 0;
   localparam int EXTRA_PWR_OFF = 1;

   localparam int EXGPIO_BYTE    = 6;
   localparam int EXGPIO_NRST_EN = 0;
   localparam int EXGPIO_NRST    = 1;
   localparam int EXGPIO_PDID_EN = 2;
   localparam int EXGPIO_PDID    = 3;
   localparam int EXGPIO_PDIC_EN = 4;
   localparam int EXGPIO_PDIC    = 5;

   localparam logic [7:0]  TRIGSRC_RST = 8'b0010_0000;           // io4 only, or mode
   localparam logic [63:0] IOROUTE_RST = 64'h0000_0000_0000_0201; // pin1 tx, pin2 rx
   localparam logic [7:0]  EXTCLK_RST  = 8'b0000_0011;

   localparam logic [USERIO_W-1:0] SWD_DIR_CLK_LOW  = 8'b0010_0000;
   localparam logic [USERIO_W-1:0] SWD_DIR_CLK_HIGH = 8'b0110_0000;
   localparam logic [USERIO_W-1:0] JTAG_DIR         = 8'b1110_0000;

endpackage
